// ==== common/kwscan_cfg.svh ====
`ifndef KWSCAN_CFG_SVH
`define KWSCAN_CFG_SVH

// Stream id space
`define KW_STREAM_W 6
`define KW_STREAMS 64

// DFA state holds the matched prefix length
`define KW_STATE_W 4

// Packet counter width per rule
`define KW_COUNT_W 16

// Rules in parallel
`define KW_RULES 2

// Wishbone byte address width
`define KW_WB_ADDR_W 5

// Register map, byte addresses
`define KW_ADDR_EN0_LO 5'h00
`define KW_ADDR_EN0_HI 5'h04
`define KW_ADDR_EN1_LO 5'h08
`define KW_ADDR_EN1_HI 5'h0C
`define KW_ADDR_CNT0 5'h10
`define KW_ADDR_CNT1 5'h14
`define KW_ADDR_FIRED 5'h18

`endif

// ==== common/kwscan_pkg.sv ====
`default_nettype none

`include "kwscan_cfg.svh"

package kwscan_pkg;

  // Token kind, selects how the payload byte is decoded
  typedef enum logic
  {
    TOK_DATA = 1'b0,
    TOK_HDR  = 1'b1
  } tok_kind_e;

  // Header view of the payload byte
  typedef struct packed
  {
    logic                    spare;
    logic                    new_stream;
    logic [`KW_STREAM_W-1:0] sid;
  } tok_hdr_t;

  // Same byte, header fields or one character
  typedef union packed
  {
    tok_hdr_t   hdr;
    logic [7:0] data;
  } tok_payload_u;

  // Top-level input word, 10 bits
  typedef struct packed
  {
    tok_kind_e    kind;
    logic         eop;
    tok_payload_u payload;
  } stream_tok_t;

  // Framer to matcher controls, each field valid for one cycle
  typedef struct packed
  {
    logic                    load_state;
    logic [`KW_STREAM_W-1:0] stream_id;
    logic                    new_stream_id;
    logic [7:0]              char;
    logic                    char_vld;
    logic                    eop;
  } match_ctl_t;

  // Wishbone classic request from master
  typedef struct packed
  {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`KW_WB_ADDR_W-1:0] adr;
    logic [31:0]              dat;
  } wb_req_t;

  // Wishbone classic response
  typedef struct packed
  {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/stream_framer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "kwscan_cfg.svh"

module stream_framer
  import kwscan_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  stream_tok_t tok,
  input  logic        tok_vld,
  output logic        tok_rdy,
  output match_ctl_t  ctl
);

  // Idle waits for a header, data streams characters
  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_RESTORE,
    ST_DATA,
    ST_DRAIN
  } fr_state_e;

  fr_state_e  state;
  logic [1:0] wait_cnt;
  logic       xfer;

  // Token moves when both sides agree
  assign xfer = tok_vld & tok_rdy;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      wait_cnt <= '0;
      tok_rdy  <= 1'b0;
      ctl      <= '0;
    end
    else
    begin
      // Strobes last one cycle only
      ctl.load_state <= 1'b0;
      ctl.char_vld   <= 1'b0;
      ctl.eop        <= 1'b0;

      case (state)
        ST_IDLE, ST_DATA:
        begin
          tok_rdy <= 1'b1;
          if (xfer)
          begin
            if (tok.kind == TOK_HDR)
            begin
              // New packet, matcher restores this stream's state
              ctl.load_state    <= 1'b1;
              ctl.stream_id     <= tok.payload.hdr.sid;
              ctl.new_stream_id <= tok.payload.hdr.new_stream;
              // Two stall cycles let the restored state reach the DFA
              tok_rdy  <= 1'b0;
              wait_cnt <= 2'd1;
              state    <= ST_RESTORE;
            end
            else
            begin
              ctl.char     <= tok.payload.data;
              ctl.char_vld <= 1'b1;
              if (tok.eop)
              begin
                // Last character, stall until its accept is through
                tok_rdy  <= 1'b0;
                wait_cnt <= 2'd3;
                state    <= ST_DRAIN;
              end
              else
                state <= ST_DATA;
            end
          end
        end

        ST_RESTORE:
        begin
          if (wait_cnt == 2'd0)
          begin
            tok_rdy <= 1'b1;
            state   <= ST_DATA;
          end
          else
            wait_cnt <= wait_cnt - 2'd1;
        end

        ST_DRAIN:
        begin
          // eop lands three cycles after the last char_vld
          if (wait_cnt == 2'd1)
            ctl.eop <= 1'b1;
          if (wait_cnt == 2'd0)
          begin
            tok_rdy <= 1'b1;
            state   <= ST_IDLE;
          end
          else
            wait_cnt <= wait_cnt - 2'd1;
        end

        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== matcher/literal_dfa.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "kwscan_cfg.svh"

module literal_dfa #(
  parameter KEYWORD = "GROUP"
)
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [7:0]             char_in,
  input  logic                   char_vld,
  input  logic [`KW_STATE_W-1:0] state_in,
  input  logic                   state_in_vld,
  output logic [`KW_STATE_W-1:0] state_out,
  output logic                   accept
);

  // Keyword length from the literal width, first character in the top byte
  localparam int         KW_LEN     = $bits(KEYWORD) / 8;
  localparam logic [7:0] FIRST_CHAR = KEYWORD[8*KW_LEN-1 -: 8];

  logic [`KW_STATE_W-1:0] state_q;
  logic [7:0]             exp_char;
  logic                   hit;
  logic                   last;

  // Keyword character expected after idx matches
  function automatic logic [7:0] kw_char(input logic [`KW_STATE_W-1:0] idx);
    if (idx < KW_LEN)
      kw_char = KEYWORD[8*(KW_LEN-1-int'(idx)) +: 8];
    else
      kw_char = 8'h00;
  endfunction

  assign exp_char  = kw_char(state_q);
  assign hit       = (char_in == exp_char);
  assign last      = (state_q == `KW_STATE_W'(KW_LEN - 1));
  assign state_out = state_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q <= '0;
      accept  <= 1'b0;
    end
    else
    begin
      accept <= 1'b0;
      // Restored state wins over any character
      if (state_in_vld)
        state_q <= state_in;
      else if (char_vld)
      begin
        if (hit && last)
        begin
          // Full keyword seen
          accept  <= 1'b1;
          state_q <= '0;
        end
        else if (hit)
          state_q <= state_q + 1'b1;
        // No repeated prefix, so only the first character can restart
        else if (char_in == FIRST_CHAR)
          state_q <= `KW_STATE_W'(1);
        else
          state_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== matcher/rule_matcher.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "kwscan_cfg.svh"

module rule_matcher
  import kwscan_pkg::*;
#(
  parameter KEYWORD = "GROUP"
)
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  match_ctl_t             ctl,
  input  logic [`KW_STREAMS-1:0] enable_map,
  output logic [`KW_COUNT_W-1:0] count,
  output logic                   fired
);

  // Saved DFA state per stream id
  logic [`KW_STATE_W-1:0] state_mem [`KW_STREAMS];

  logic [`KW_STATE_W-1:0] state_in;
  logic                   state_in_vld;

  // DFA input and output registers
  logic [7:0]             char_r;
  logic                   char_vld_r;
  logic [`KW_STATE_W-1:0] state_in_r;
  logic                   state_in_vld_r;
  logic [`KW_STATE_W-1:0] state_out;
  logic [`KW_STATE_W-1:0] state_out_r;
  logic                   accept;
  logic                   accept_r;

  logic spec_match;
  logic spec_next;
  logic stream_en;

  // Accept arriving with eop still counts for this packet
  assign spec_next = spec_match | accept_r;
  assign stream_en = enable_map[ctl.stream_id];
  assign fired     = spec_match;

  // Restore on packet start, zero for a fresh stream
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_in_vld <= 1'b0;
    else
      state_in_vld <= ctl.load_state;
  end

  always_ff @(posedge clk)
  begin
    if (ctl.load_state)
      state_in <= ctl.new_stream_id ? '0 : state_mem[ctl.stream_id];
  end

  // Save only for enabled streams
  always_ff @(posedge clk)
  begin
    if (ctl.eop && stream_en)
      state_mem[ctl.stream_id] <= state_out_r;
  end

  // One register stage on each side of the DFA
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_r     <= 1'b0;
      state_in_vld_r <= 1'b0;
      accept_r       <= 1'b0;
    end
    else
    begin
      char_vld_r     <= ctl.char_vld;
      state_in_vld_r <= state_in_vld;
      accept_r       <= accept;
    end
  end

  always_ff @(posedge clk)
  begin
    char_r      <= ctl.char;
    state_in_r  <= state_in;
    state_out_r <= state_out;
  end

  // Flag and count, later assignments take priority
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count      <= '0;
      spec_match <= 1'b0;
    end
    else
    begin
      if (ctl.load_state)
        spec_match <= 1'b0;
      if (accept_r)
        spec_match <= 1'b1;
      if (ctl.eop)
      begin
        if (stream_en)
        begin
          count      <= count + {{(`KW_COUNT_W-1){1'b0}}, spec_next};
          spec_match <= spec_next;
        end
        else
          // Disabled rule, nothing to report for this packet
          spec_match <= 1'b0;
      end
    end
  end

  literal_dfa #(
    .KEYWORD(KEYWORD)
  ) u_dfa (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (char_r),
    .char_vld     (char_vld_r),
    .state_in     (state_in_r),
    .state_in_vld (state_in_vld_r),
    .state_out    (state_out),
    .accept       (accept)
  );

endmodule

`default_nettype wire

// ==== hdl/wb_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "kwscan_cfg.svh"

module wb_regs
  import kwscan_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  wb_req_t                wb_req,
  output wb_rsp_t                wb_rsp,
  input  logic [`KW_COUNT_W-1:0] count0,
  input  logic [`KW_COUNT_W-1:0] count1,
  input  logic [`KW_RULES-1:0]   fired,
  output logic [`KW_STREAMS-1:0] enable_map0,
  output logic [`KW_STREAMS-1:0] enable_map1
);

  logic        ack_q;
  logic [31:0] dat_q;
  logic [31:0] rd_data;
  logic        req_new;

  // Request that is not already in its ack cycle
  assign req_new = wb_req.cyc & wb_req.stb & ~ack_q;

  assign wb_rsp = '{ack: ack_q, dat: dat_q};

  // Read mux where unmapped addresses give zero
  always_comb
  begin
    case (wb_req.adr)
      `KW_ADDR_EN0_LO: rd_data = enable_map0[31:0];
      `KW_ADDR_EN0_HI: rd_data = enable_map0[63:32];
      `KW_ADDR_EN1_LO: rd_data = enable_map1[31:0];
      `KW_ADDR_EN1_HI: rd_data = enable_map1[63:32];
      `KW_ADDR_CNT0:   rd_data = {{(32-`KW_COUNT_W){1'b0}}, count0};
      `KW_ADDR_CNT1:   rd_data = {{(32-`KW_COUNT_W){1'b0}}, count1};
      `KW_ADDR_FIRED:  rd_data = {{(32-`KW_RULES){1'b0}}, fired};
      default:         rd_data = 32'h0;
    endcase
  end

  // Single-cycle ack
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      ack_q <= 1'b0;
    else
      ack_q <= req_new;
  end

  always_ff @(posedge clk)
  begin
    if (req_new)
      dat_q <= rd_data;
  end

  // Enable words, counts and fired ignore writes
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      enable_map0 <= '0;
      enable_map1 <= '0;
    end
    else if (req_new && wb_req.we)
    begin
      case (wb_req.adr)
        `KW_ADDR_EN0_LO: enable_map0[31:0]  <= wb_req.dat;
        `KW_ADDR_EN0_HI: enable_map0[63:32] <= wb_req.dat;
        `KW_ADDR_EN1_LO: enable_map1[31:0]  <= wb_req.dat;
        `KW_ADDR_EN1_HI: enable_map1[63:32] <= wb_req.dat;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/kwscan_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "kwscan_cfg.svh"

module kwscan_top
  import kwscan_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  stream_tok_t tok,
  input  logic        tok_vld,
  output logic        tok_rdy,
  input  wb_req_t     wb_req,
  output wb_rsp_t     wb_rsp
);

  // Shared control to both rules
  match_ctl_t ctl;

  logic [`KW_STREAMS-1:0] enable_map0;
  logic [`KW_STREAMS-1:0] enable_map1;
  logic [`KW_COUNT_W-1:0] count0;
  logic [`KW_COUNT_W-1:0] count1;
  logic [`KW_RULES-1:0]   fired;

  stream_framer u_framer (
    .clk     (clk),
    .rst_n   (rst_n),
    .tok     (tok),
    .tok_vld (tok_vld),
    .tok_rdy (tok_rdy),
    .ctl     (ctl)
  );

  // Rule 0
  rule_matcher #(
    .KEYWORD("GROUP")
  ) u_rule_group (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctl        (ctl),
    .enable_map (enable_map0),
    .count      (count0),
    .fired      (fired[0])
  );

  // Rule 1
  rule_matcher #(
    .KEYWORD("ARTICLE")
  ) u_rule_article (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctl        (ctl),
    .enable_map (enable_map1),
    .count      (count1),
    .fired      (fired[1])
  );

  wb_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .count0      (count0),
    .count1      (count1),
    .fired       (fired),
    .enable_map0 (enable_map0),
    .enable_map1 (enable_map1)
  );

endmodule

`default_nettype wire

// ==== verif/kwscan_props.sv ====
`default_nettype none
`timescale 1ns/1ps

module kwscan_props
  import kwscan_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       tok_rdy,
  input wb_req_t    wb_req,
  input wb_rsp_t    wb_rsp,
  input match_ctl_t ctl
);

  // Ack rises one cycle after the strobe of a new bus cycle
  ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_req.cyc && wb_req.stb) |-> !wb_rsp.ack ##1 wb_rsp.ack)
    else $error("Wishbone ack missing one cycle after a new strobe");

  // Sync reset clears both handshake outputs
  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> (!wb_rsp.ack && !tok_rdy))
    else $error("ack or tok_rdy high during reset");

  // tok_rdy stays low the first cycle out of reset
  ready_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !tok_rdy)
    else $error("tok_rdy high in the first cycle after reset");

  // Framer stalls while the saved state travels to the DFA
  restore_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (ctl.load_state || $past(ctl.load_state)) |-> !tok_rdy)
    else $error("tok_rdy high during the restore wait");

  restore_no_char: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(ctl.load_state) || $past(ctl.load_state, 2)) |-> !ctl.char_vld)
    else $error("char_vld issued during the restore wait");

endmodule

`default_nettype wire

// ==== verif/kwscan_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "kwscan_cfg.svh"

module kwscan_tb
  import kwscan_pkg::*;
();

  logic        clk;
  logic        rst_n;
  stream_tok_t tok;
  logic        tok_vld;
  logic        tok_rdy;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;

  // Commands parsed from the pattern file
  byte unsigned cmd_q [$];
  logic [31:0]  arg_a_q [$];
  logic [31:0]  arg_b_q [$];

  int cycle_cnt   = 0;
  int cycle_limit = 0;

  kwscan_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .tok     (tok),
    .tok_vld (tok_vld),
    .tok_rdy (tok_rdy),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp)
  );

  // Handshake and reset checks on the top level
  bind kwscan_top kwscan_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .tok_rdy (tok_rdy),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .ctl     (ctl)
  );

  // 8 ns clock
  initial
  begin
    clk = 1'b0;
    forever
      #4 clk = ~clk;
  end

  // Print the reason, then end the run as failed
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Testbench stopped on the first error");
  endtask

  // Hang guard with its limit set once the pattern file is parsed
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      stop_run($sformatf("Timeout after %0d cycles, the DUT appears to hang", cycle_cnt));
  end

  function automatic string reg_name(input logic [`KW_WB_ADDR_W-1:0] adr);
    case (adr)
      `KW_ADDR_EN0_LO: reg_name = "en0_lo";
      `KW_ADDR_EN0_HI: reg_name = "en0_hi";
      `KW_ADDR_EN1_LO: reg_name = "en1_lo";
      `KW_ADDR_EN1_HI: reg_name = "en1_hi";
      `KW_ADDR_CNT0:   reg_name = "count0";
      `KW_ADDR_CNT1:   reg_name = "count1";
      `KW_ADDR_FIRED:  reg_name = "fired";
      default:         reg_name = $sformatf("unmapped_0x%02h", adr);
    endcase
  endfunction

  task automatic check_count(input string name, input logic [`KW_COUNT_W-1:0] exp_val,
                             input logic [`KW_COUNT_W-1:0] act_val);
    if (act_val !== exp_val)
      stop_run($sformatf("ERROR at %0t ns: %s expected 0x%0h, actual 0x%0h",
                         $time, name, exp_val, act_val));
  endtask

  task automatic check_fired(input string name, input logic [`KW_RULES-1:0] exp_val,
                             input logic [`KW_RULES-1:0] act_val);
    if (act_val !== exp_val)
      stop_run($sformatf("ERROR at %0t ns: %s expected 0b%b, actual 0b%b",
                         $time, name, exp_val, act_val));
  endtask

  task automatic check_word(input string name, input logic [31:0] exp_val,
                            input logic [31:0] act_val);
    if (act_val !== exp_val)
      stop_run($sformatf("ERROR at %0t ns: %s expected 0x%08h, actual 0x%08h",
                         $time, name, exp_val, act_val));
  endtask

  // Pick the compare that fits the register read back
  task automatic check_read(input logic [`KW_WB_ADDR_W-1:0] adr, input logic [31:0] exp_val,
                            input logic [31:0] act_val);
    case (adr)
      `KW_ADDR_CNT0, `KW_ADDR_CNT1:
        check_count(reg_name(adr), exp_val[`KW_COUNT_W-1:0], act_val[`KW_COUNT_W-1:0]);
      `KW_ADDR_FIRED:
        check_fired(reg_name(adr), exp_val[`KW_RULES-1:0], act_val[`KW_RULES-1:0]);
      default:
        check_word(reg_name(adr), exp_val, act_val);
    endcase
  endtask

  // Called on a falling edge; returns on the falling edge after the transfer
  task automatic send_token(input stream_tok_t t);
    int gap;
    tok     = t;
    tok_vld = 1'b1;
    // tok_rdy only moves on the rising edge, so this value is what the edge sees
    while (tok_rdy !== 1'b1)
      @(negedge clk);
    @(negedge clk);
    tok_vld = 1'b0;
    gap     = $urandom % 4;
    repeat (gap)
      @(negedge clk);
  endtask

  // Framer back in idle or data means the last eop has been counted
  task automatic wait_idle();
    while (tok_rdy !== 1'b1)
      @(negedge clk);
  endtask

  task automatic wb_access(input logic we, input logic [`KW_WB_ADDR_W-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    @(negedge clk);
    while (wb_rsp.ack !== 1'b1)
      @(negedge clk);
    rdat   = wb_rsp.dat;
    wb_req = '0;
    // One idle cycle between bus cycles
    @(negedge clk);
  endtask

  task automatic load_patterns();
    int           fd;
    int           n;
    logic [63:0]  word;
    logic [1023:0] rest;
    logic [31:0]  a;
    logic [31:0]  b;
    fd = $fopen("verif/kwscan_patterns.txt", "r");
    if (fd == 0)
      stop_run("Could not open the pattern file verif/kwscan_patterns.txt");
    else
    begin
      while (!$feof(fd))
      begin
        word = '0;
        n    = $fscanf(fd, "%s", word);
        if (n != 1)
          break;
        if (word == "#")
          n = $fgets(rest, fd);
        else if (word == "H" || word == "D" || word == "W" || word == "R")
        begin
          n = $fscanf(fd, "%h %h", a, b);
          if (n != 2)
            stop_run("Malformed line in the pattern file, two hex fields expected");
          else
          begin
            cmd_q.push_back(word[7:0]);
            arg_a_q.push_back(a);
            arg_b_q.push_back(b);
          end
        end
        else
          stop_run("Unknown command in the pattern file");
      end
      $fclose(fd);
    end
  endtask

  task automatic run_command(input byte unsigned cmd, input logic [31:0] a,
                             input logic [31:0] b);
    stream_tok_t t;
    logic [31:0] rdat;
    t = '0;
    case (cmd)
      "H":
      begin
        t.kind                   = TOK_HDR;
        t.payload.hdr.sid        = a[`KW_STREAM_W-1:0];
        t.payload.hdr.new_stream = b[0];
        send_token(t);
      end
      "D":
      begin
        t.kind         = TOK_DATA;
        t.eop          = b[0];
        t.payload.data = a[7:0];
        send_token(t);
      end
      "W":
      begin
        wait_idle();
        wb_access(1'b1, a[`KW_WB_ADDR_W-1:0], b, rdat);
      end
      default:
      begin
        // Register read compared with the expected word
        wait_idle();
        wb_access(1'b0, a[`KW_WB_ADDR_W-1:0], 32'h0, rdat);
        check_read(a[`KW_WB_ADDR_W-1:0], b, rdat);
      end
    endcase
  endtask

  initial
  begin
    tok     = '0;
    tok_vld = 1'b0;
    wb_req  = '0;
    rst_n   = 1'b0;
    void'($urandom(82));
    load_patterns();
    // Generous per-command budget on top of reset and drain
    cycle_limit = 20 * cmd_q.size() + 200;
    repeat (8)
      @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < cmd_q.size(); i++)
      run_command(cmd_q[i], arg_a_q[i], arg_b_q[i]);
    wait_idle();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/kwscan_patterns.txt ====
# Columns: cmd a b, all hex. H sid new | D char eop | W addr data | R addr expected
# Rule 0 on streams 3, 5 and 40; rule 1 on stream 3 only
W 00 00000028
W 04 00000100
W 08 00000008
R 00 00000028
R 04 00000100
R 08 00000008
R 0c 00000000
R 1c 00000000
# GROUP on stream 3
H 03 1
D 47 0
D 52 0
D 4f 0
D 55 0
D 50 1
R 10 00000001
R 14 00000000
R 18 00000001
# GROUP ARTICLE GROUP GROUP in one packet, each rule counts once
H 03 1
D 47 0
D 52 0
D 4f 0
D 55 0
D 50 0
D 41 0
D 52 0
D 54 0
D 49 0
D 43 0
D 4c 0
D 45 0
D 47 0
D 52 0
D 4f 0
D 55 0
D 50 0
D 47 0
D 52 0
D 4f 0
D 55 0
D 50 1
R 10 00000002
R 14 00000001
R 18 00000003
# Stream 7 is disabled for both rules
H 07 1
D 47 0
D 52 0
D 4f 0
D 55 0
D 50 1
R 10 00000002
R 18 00000000
# GRO then UP on stream 5, resumed
H 05 1
D 47 0
D 52 0
D 4f 1
H 05 0
D 55 0
D 50 1
R 10 00000003
# Same split with the second header new
H 05 1
D 47 0
D 52 0
D 4f 1
H 05 1
D 55 0
D 50 1
R 10 00000003
R 18 00000000
# Streams 3 and 40 interleaved
H 03 1
D 47 0
D 52 1
H 28 1
D 47 0
D 52 0
D 4f 1
H 03 0
D 4f 0
D 55 0
D 50 1
H 28 0
D 55 0
D 50 1
R 10 00000005
R 14 00000001
# Read-only and enable registers
W 10 0000ffff
W 18 00000003
R 10 00000005
R 18 00000001
W 0c 12345678
R 0c 12345678
W 04 a5a5a5a5
R 04 a5a5a5a5
R 1c 00000000
R 14 00000001

// ==== list.f ====
+incdir+common
common/kwscan_pkg.sv
hdl/stream_framer.sv
matcher/literal_dfa.sv
matcher/rule_matcher.sv
hdl/wb_regs.sv
hdl/kwscan_top.sv
verif/kwscan_props.sv
verif/kwscan_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the keyword scanner testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module kwscan_tb -o kwscan_sim

# The simulator exits non-zero on failure; the log decides the result
./obj_dir/kwscan_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "Simulation ended without a pass line"
  exit 1
fi
echo "Simulation finished cleanly"
